// File: dcache.f
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_ctrl.sv
tag_array.sv
data_array.sv
plru_table.sv
load_align.sv
dcache_top.sv
tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dcache -f dcache.f -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "Done: no errors" "$LOG"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    // about 45 requests, at most ~20 cycles per miss, so a run needs well under 500 cycles
    localparam int MAX_CYCLES  = 4000;
    localparam int REQ_TIMEOUT = 64;     // dirty miss takes about 20 cycles at most
    localparam int MEM_WORDS   = 4096;   // 16 KB window of the memory
    localparam int WORD_W      = dcache_geom_pkg::WORD_W;

    logic clk;
    logic arst_n;
    logic busy;
    dcache_bus_pkg::cpu_req_t  cpu_req;
    dcache_bus_pkg::cpu_resp_t cpu_resp;
    dcache_bus_pkg::mem_req_t  mem_req;
    dcache_bus_pkg::mem_resp_t mem_resp;

    dcache_geom_pkg::word_t mem_words [MEM_WORDS];
    dcache_geom_pkg::word_t exp_words [MEM_WORDS];   // what memory should hold incl. stores
    dcache_geom_pkg::addr_t wb_log [$];
    dcache_geom_pkg::addr_t exp_wb [$];
    dcache_geom_pkg::addr_t access_order [$];
    logic                   access_write [$];

    integer seed = 32'h5bc4;
    int     cycle_count = 0;
    logic   last_resp_busy;

    dcache_top #(.ASSOC_NUM(4)) dcache_top_inst (
        .clk(clk), .arst_n(arst_n), .cpu_req(cpu_req), .mem_resp(mem_resp),
        .cpu_resp(cpu_resp), .busy(busy), .mem_req(mem_req)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run("timeout: the tests did not finish within 4000 clock cycles");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_error(input string msg);
        abort_run($sformatf("ERROR at %0t: %s", $time, msg));
    endtask

    task automatic check_word(input dcache_geom_pkg::word_t got,
                              input dcache_geom_pkg::word_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_line(input dcache_geom_pkg::line_t got,
                              input dcache_geom_pkg::line_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %032h, expected %032h", what, got, exp));
        end
    endtask

    task automatic check_addr(input dcache_geom_pkg::addr_t got,
                              input dcache_geom_pkg::addr_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    function automatic int word_index(input dcache_geom_pkg::addr_t a);
        return int'(a[13:2]);
    endfunction

    function automatic dcache_geom_pkg::line_t mem_line(input dcache_geom_pkg::addr_t a);
        dcache_geom_pkg::line_t l;
        for (int k = 0; k < dcache_geom_pkg::LINE_WORDS; k++) begin
            l[k*WORD_W +: WORD_W] = mem_words[word_index(a) + k];
        end
        return l;
    endfunction

    function automatic dcache_geom_pkg::line_t exp_line(input dcache_geom_pkg::addr_t a);
        dcache_geom_pkg::line_t l;
        for (int k = 0; k < dcache_geom_pkg::LINE_WORDS; k++) begin
            l[k*WORD_W +: WORD_W] = exp_words[word_index(a) + k];
        end
        return l;
    endfunction

    // extension rule applied to the expected word
    function automatic dcache_geom_pkg::word_t expected_load(
        input dcache_geom_pkg::word_t w, input logic [1:0] off,
        input dcache_bus_pkg::load_type_e lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = 16'(w >> (16 * off[1]));
        case (lt)
            dcache_bus_pkg::LOAD_H:  return {{16{h[15]}}, h};
            dcache_bus_pkg::LOAD_HU: return {16'h0000, h};
            dcache_bus_pkg::LOAD_B:  return {{24{b[7]}}, b};
            dcache_bus_pkg::LOAD_BU: return {24'h000000, b};
            default:                 return w;
        endcase
    endfunction

    function automatic int plru_pick(input logic [2:0] bits);
        if (!bits[0]) begin
            return bits[1] ? 1 : 0;
        end
        return bits[2] ? 3 : 2;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] bits, input int way);
        logic [2:0] b;
        b = bits;
        if (way < 2) begin
            b[0] = 1'b1;
            b[1] = (way == 0);
        end else begin
            b[0] = 1'b0;
            b[2] = (way == 2);
        end
        return b;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // line memory, random 0..3 cycle delays on every handshake step
    initial begin : memory_model
        dcache_geom_pkg::addr_t line_addr;
        mem_resp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.wr_req) begin
                wait_cycles({$random(seed)} % 4);
                line_addr        = mem_req.wr_addr;
                mem_resp.wr_rdy  = 1'b1;
                for (int k = 0; k < dcache_geom_pkg::LINE_WORDS; k++) begin
                    mem_words[word_index(line_addr) + k] = mem_req.wr_data[k*WORD_W +: WORD_W];
                end
                wb_log.push_back(line_addr);
                wait_cycles(1);
                mem_resp.wr_rdy  = 1'b0;
                wait_cycles({$random(seed)} % 4);
                mem_resp.wr_done = 1'b1;
                wait_cycles(1);
                mem_resp.wr_done = 1'b0;
            end else if (mem_req.rd_req) begin
                wait_cycles({$random(seed)} % 4);
                line_addr          = mem_req.rd_addr;
                mem_resp.rd_rdy    = 1'b1;
                wait_cycles(1);
                mem_resp.rd_rdy    = 1'b0;
                wait_cycles({$random(seed)} % 4);
                mem_resp.ret_data  = mem_line(line_addr);
                mem_resp.ret_valid = 1'b1;
                wait_cycles(1);
                mem_resp.ret_valid = 1'b0;
            end
        end
    end

    // one request, cycles counts from the acceptance edge to the response
    task automatic cpu_access(input logic write, input dcache_geom_pkg::addr_t addr,
                              input dcache_geom_pkg::byte_en_t wstrb,
                              input dcache_geom_pkg::word_t wdata,
                              input dcache_bus_pkg::load_type_e lt,
                              output dcache_geom_pkg::word_t rdata, output int cycles);
        dcache_bus_pkg::cpu_req_t req;
        req.valid     = 1'b1;
        req.write     = write;
        req.addr      = addr;
        req.wstrb     = wstrb;
        req.wdata     = wdata;
        req.load_type = lt;
        @(posedge clk);
        #1;
        check_bit(busy, 1'b0, "busy before a new request");
        cpu_req = req;
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > REQ_TIMEOUT) begin
                abort_run($sformatf("no response from the cache for address %08h", addr));
            end
        end while (!cpu_resp.valid);
        rdata          = cpu_resp.rdata;
        last_resp_busy = busy;
    endtask

    task automatic do_store(input dcache_geom_pkg::addr_t addr,
                            input dcache_geom_pkg::byte_en_t wstrb,
                            input dcache_geom_pkg::word_t wdata);
        dcache_geom_pkg::word_t rdata;
        int cycles;
        cpu_access(1'b1, addr, wstrb, wdata, dcache_bus_pkg::LOAD_W, rdata, cycles);
        check_word(rdata, '0, "store response data");
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                exp_words[word_index(addr)][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic load_and_compare(input dcache_geom_pkg::addr_t addr,
                                    input dcache_bus_pkg::load_type_e lt, output int cycles);
        dcache_geom_pkg::word_t rdata;
        cpu_access(1'b0, addr, '0, '0, lt, rdata, cycles);
        check_word(rdata, expected_load(exp_words[word_index(addr)], addr[1:0], lt),
                   $sformatf("load %s at %08h", lt.name(), addr));
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_bit(busy, 1'b0, "busy after reset");
            check_bit(mem_req.rd_req, 1'b0, "rd_req after reset");
            check_bit(mem_req.wr_req, 1'b0, "wr_req after reset");
            check_bit(cpu_resp.valid, 1'b0, "response without request");
        end
    endtask

    task automatic miss_then_hit();
        int cycles;
        load_and_compare(32'h0000_0100, dcache_bus_pkg::LOAD_W, cycles);
        check_bit(cycles > 1, 1'b1, "first load to a fresh line misses");
        load_and_compare(32'h0000_0104, dcache_bus_pkg::LOAD_W, cycles);
        check_bit(cycles == 1, 1'b1, "load to a cached line answers in one cycle");
        check_bit(last_resp_busy, 1'b0, "busy in the hit cycle");
    endtask

    task automatic sub_word_loads();
        dcache_geom_pkg::addr_t a;
        int cycles;
        do_store(32'h0000_020C, 4'hF, 32'h817F_80FE);   // mixed sign bytes
        for (int w = 0; w < 2; w++) begin
            for (int off = 0; off < 4; off++) begin
                a = 32'h0000_0208 + w * 4 + off;
                load_and_compare(a, dcache_bus_pkg::LOAD_B, cycles);
                load_and_compare(a, dcache_bus_pkg::LOAD_BU, cycles);
                if (off % 2 == 0) begin
                    load_and_compare(a, dcache_bus_pkg::LOAD_H, cycles);
                    load_and_compare(a, dcache_bus_pkg::LOAD_HU, cycles);
                end
            end
            load_and_compare(32'h0000_0208 + w * 4, dcache_bus_pkg::LOAD_W, cycles);
        end
    endtask

    task automatic store_merge();
        int cycles;
        do_store(32'h0000_0300, 4'b0011, 32'h1122_3344);   // store miss
        do_store(32'h0000_0304, 4'b1000, 32'h5566_7788);
        do_store(32'h0000_0308, 4'b0110, 32'h99AA_BBCC);
        do_store(32'h0000_0300, 4'b1100, 32'hDDEE_FF00);
        for (int k = 0; k < 4; k++) begin
            load_and_compare(32'h0000_0300 + k * 4, dcache_bus_pkg::LOAD_W, cycles);
        end
    endtask

    // replays the recorded accesses through a 4-way tree PLRU
    task automatic predict_writebacks();
        logic [2:0]            bits;
        dcache_geom_pkg::tag_t way_tag [4];
        logic [3:0]            way_valid;
        logic [3:0]            way_dirty;
        dcache_geom_pkg::tag_t t;
        int                    way;
        bits      = '0;
        way_valid = '0;
        way_dirty = '0;
        exp_wb.delete();
        foreach (access_order[i]) begin
            t   = access_order[i][31:10];
            way = -1;
            for (int w = 0; w < 4; w++) begin
                if (way_valid[w] && way_tag[w] == t) begin
                    way = w;
                end
            end
            if (way < 0) begin
                way = plru_pick(bits);
                if (way_valid[way] && way_dirty[way]) begin
                    exp_wb.push_back({way_tag[way], access_order[i][9:4], 4'h0});
                end
                way_valid[way] = 1'b1;
                way_dirty[way] = 1'b0;
                way_tag[way]   = t;
            end
            if (access_write[i]) begin
                way_dirty[way] = 1'b1;
            end
            bits = plru_touch(bits, way);
        end
    endtask

    task automatic eviction_writebacks();
        dcache_geom_pkg::addr_t a;
        int cycles;
        int wb_base;
        wb_base = wb_log.size();
        for (int k = 0; k < 5; k++) begin
            a = 32'h0000_0050 + k * 32'h400;   // same set, new tag each time
            do_store(a + (k % 4) * 4, 4'hF, 32'hC0DE_0000 + k);
            access_order.push_back(a);
            access_write.push_back(1'b1);
        end
        a = 32'h0000_0050 + 5 * 32'h400;
        load_and_compare(a, dcache_bus_pkg::LOAD_W, cycles);
        access_order.push_back(a);
        access_write.push_back(1'b0);
        predict_writebacks();
        if (wb_log.size() - wb_base != exp_wb.size()) begin
            report_error($sformatf("%0d writebacks seen, %0d expected",
                                   wb_log.size() - wb_base, exp_wb.size()));
        end
        foreach (exp_wb[i]) begin
            check_addr(wb_log[wb_base + i], exp_wb[i], "writeback address");
            check_line(mem_line(exp_wb[i]), exp_line(exp_wb[i]), "written back line");
        end
    endtask

    task automatic evicted_reload();
        int cycles;
        foreach (exp_wb[i]) begin
            load_and_compare(exp_wb[i] + (i % 4) * 4, dcache_bus_pkg::LOAD_W, cycles);
            check_bit(cycles > 1, 1'b1, "evicted line is refilled");
        end
    endtask

    initial begin : main_sequence
        cpu_req = '0;
        arst_n  = 1'b0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem_words[k] = (k * 4) ^ 32'hA5A5_0000;
            exp_words[k] = mem_words[k];
        end
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        idle_after_reset();
        miss_then_hit();
        sub_word_loads();
        store_merge();
        eviction_writebacks();
        evicted_reload();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int ASSOC_NUM = 4
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire dcache_bus_pkg::cpu_req_t  cpu_req,
    input  wire dcache_bus_pkg::mem_resp_t mem_resp,
    output dcache_bus_pkg::cpu_resp_t      cpu_resp,
    output logic                           busy,
    output dcache_bus_pkg::mem_req_t       mem_req
);

    localparam int BYTE_OFF_W = $clog2(dcache_geom_pkg::WORD_W / 8);

    dcache_bus_pkg::cpu_req_t  held_req;
    dcache_geom_pkg::tag_t     held_tag;
    dcache_geom_pkg::index_t   held_index;
    dcache_geom_pkg::word_sel_t word_sel;
    dcache_geom_pkg::tag_t     victim_tag;
    dcache_geom_pkg::line_t    victim_line;
    dcache_geom_pkg::word_t    hit_word;
    dcache_geom_pkg::word_t    load_data;

    logic [ASSOC_NUM-1:0] hit;
    logic [ASSOC_NUM-1:0] victim;
    logic victim_dirty;
    logic resp_valid;
    logic rd_req;
    logic wr_req;
    logic refill_we;
    logic store_we;
    logic lru_update;

    assign held_tag   = held_req.addr[dcache_geom_pkg::ADDR_W-1 -: dcache_geom_pkg::TAG_W];
    assign held_index = held_req.addr[dcache_geom_pkg::OFFSET_W +: dcache_geom_pkg::INDEX_W];
    assign word_sel   = held_req.addr[BYTE_OFF_W +: $bits(dcache_geom_pkg::word_sel_t)];

    dcache_ctrl #(.ASSOC_NUM(ASSOC_NUM)) dcache_ctrl_inst (
        .clk(clk), .arst_n(arst_n), .cpu_req(cpu_req), .mem_resp(mem_resp),
        .hit(hit), .victim_dirty(victim_dirty), .held_req(held_req), .busy(busy),
        .resp_valid(resp_valid), .rd_req(rd_req), .wr_req(wr_req),
        .refill_we(refill_we), .store_we(store_we), .lru_update(lru_update)
    );

    tag_array #(.ASSOC_NUM(ASSOC_NUM)) tag_array_inst (
        .clk(clk), .arst_n(arst_n), .index(held_index), .tag(held_tag),
        .victim(victim), .refill_we(refill_we), .store_we(store_we),
        .hit(hit), .victim_tag(victim_tag), .victim_dirty(victim_dirty)
    );

    data_array #(.ASSOC_NUM(ASSOC_NUM)) data_array_inst (
        .clk(clk), .index(held_index), .word_sel(word_sel), .hit(hit), .victim(victim),
        .refill_we(refill_we), .refill_line(mem_resp.ret_data), .store_we(store_we),
        .wstrb(held_req.wstrb), .wdata(held_req.wdata),
        .hit_word(hit_word), .victim_line(victim_line)
    );

    plru_table #(.ASSOC_NUM(ASSOC_NUM)) plru_table_inst (
        .clk(clk), .arst_n(arst_n), .index(held_index), .hit(hit),
        .update(lru_update), .victim(victim)
    );

    load_align load_align_inst (
        .word(hit_word), .byte_off(held_req.addr[1:0]),
        .load_type(held_req.load_type), .rdata(load_data)
    );

    always_comb begin
        mem_req.rd_req  = rd_req;
        mem_req.wr_req  = wr_req;
        mem_req.rd_addr = {held_tag, held_index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        mem_req.wr_addr = {victim_tag, held_index, {dcache_geom_pkg::OFFSET_W{1'b0}}};
        mem_req.wr_data = victim_line;
    end

    assign cpu_resp.valid = resp_valid;
    assign cpu_resp.rdata = held_req.write ? '0 : load_data;   // stores answer zero

endmodule

`default_nettype wire

// File: load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire dcache_geom_pkg::word_t     word,
    input  wire logic [1:0]                 byte_off,
    input  wire dcache_bus_pkg::load_type_e load_type,
    output dcache_geom_pkg::word_t          rdata
);

    logic [15:0] half;
    logic [7:0]  byte_val;

    assign half     = byte_off[1] ? word[31:16] : word[15:0];
    assign byte_val = word[byte_off*8 +: 8];

    always_comb begin
        unique case (load_type)
            dcache_bus_pkg::LOAD_H: begin
                rdata = {{16{half[15]}}, half};
            end
            dcache_bus_pkg::LOAD_HU: begin
                rdata = {16'b0, half};
            end
            dcache_bus_pkg::LOAD_B: begin
                rdata = {{24{byte_val[7]}}, byte_val};
            end
            dcache_bus_pkg::LOAD_BU: begin
                rdata = {24'b0, byte_val};
            end
            default: begin
                rdata = word;   // LOAD_W
            end
        endcase
    end

endmodule

`default_nettype wire

// File: plru_table.sv
`timescale 1ns/1ps
`default_nettype none

module plru_table #(
    parameter int ASSOC_NUM = 4
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire dcache_geom_pkg::index_t index,
    input  wire logic [ASSOC_NUM-1:0]    hit,
    input  wire logic                    update,
    output logic [ASSOC_NUM-1:0]         victim
);

    localparam int LEVELS = $clog2(ASSOC_NUM);

    // node n has children 2n+1 (lower half) and 2n+2 (upper half)
    logic [dcache_geom_pkg::SET_NUM-1:0][ASSOC_NUM-2:0] plru_q;

    logic [ASSOC_NUM-2:0] cur_bits;
    logic [ASSOC_NUM-2:0] upd_bits;
    logic [LEVELS-1:0]    hit_way;

    assign cur_bits = plru_q[index];

    always_comb begin
        int node;
        int way;
        node = 0;
        way  = 0;
        for (int l = 0; l < LEVELS; l++) begin
            way  = way * 2 + int'(cur_bits[node]);
            node = node * 2 + 1 + int'(cur_bits[node]);
        end
        victim      = '0;
        victim[way] = 1'b1;
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (hit[w]) begin
                hit_way = LEVELS'(w);
            end
        end
    end

    // every bit on the hit path turns away from the hit way
    always_comb begin
        int   node;
        logic dir;
        upd_bits = cur_bits;
        node     = 0;
        for (int l = 0; l < LEVELS; l++) begin
            dir            = hit_way[LEVELS-1-l];
            upd_bits[node] = ~dir;
            node           = node * 2 + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            plru_q <= '0;
        end else if (update) begin
            plru_q[index] <= upd_bits;
        end
    end

endmodule

`default_nettype wire

// File: data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array #(
    parameter int ASSOC_NUM = 4
) (
    input  wire logic                       clk,
    input  wire dcache_geom_pkg::index_t    index,
    input  wire dcache_geom_pkg::word_sel_t word_sel,
    input  wire logic [ASSOC_NUM-1:0]       hit,
    input  wire logic [ASSOC_NUM-1:0]       victim,
    input  wire logic                       refill_we,
    input  wire dcache_geom_pkg::line_t     refill_line,
    input  wire logic                       store_we,
    input  wire dcache_geom_pkg::byte_en_t  wstrb,
    input  wire dcache_geom_pkg::word_t     wdata,
    output dcache_geom_pkg::word_t          hit_word,
    output dcache_geom_pkg::line_t          victim_line
);

    dcache_geom_pkg::line_t data_mem [ASSOC_NUM][dcache_geom_pkg::SET_NUM];

    dcache_geom_pkg::line_t hit_line;
    dcache_geom_pkg::line_t store_line;   // hit line with the store merged in

    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (hit[w]) begin
                hit_line = data_mem[w][index];
            end
            if (victim[w]) begin
                victim_line = data_mem[w][index];
            end
        end
    end

    assign hit_word = hit_line[word_sel*dcache_geom_pkg::WORD_W +: dcache_geom_pkg::WORD_W];

    always_comb begin
        store_line = hit_line;
        for (int b = 0; b < dcache_geom_pkg::WORD_W / 8; b++) begin
            if (wstrb[b]) begin
                store_line[word_sel*dcache_geom_pkg::WORD_W + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (refill_we && victim[w]) begin
                data_mem[w][index] <= refill_line;
            end else if (store_we && hit[w]) begin
                data_mem[w][index] <= store_line;
            end
        end
    end

endmodule

`default_nettype wire

// File: tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array #(
    parameter int ASSOC_NUM = 4
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire dcache_geom_pkg::index_t index,
    input  wire dcache_geom_pkg::tag_t   tag,
    input  wire logic [ASSOC_NUM-1:0]    victim,
    input  wire logic                    refill_we,
    input  wire logic                    store_we,
    output logic [ASSOC_NUM-1:0]         hit,
    output dcache_geom_pkg::tag_t        victim_tag,
    output logic                         victim_dirty
);

    logic [ASSOC_NUM-1:0][dcache_geom_pkg::SET_NUM-1:0] valid_q;
    logic [ASSOC_NUM-1:0][dcache_geom_pkg::SET_NUM-1:0] dirty_q;

    dcache_geom_pkg::tag_t tag_mem [ASSOC_NUM][dcache_geom_pkg::SET_NUM];

    always_comb begin
        victim_tag   = '0;
        victim_dirty = 1'b0;
        for (int w = 0; w < ASSOC_NUM; w++) begin
            hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
            if (victim[w]) begin
                victim_tag   = tag_mem[w][index];
                victim_dirty = valid_q[w][index] && dirty_q[w][index];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < ASSOC_NUM; w++) begin
                if (refill_we && victim[w]) begin
                    valid_q[w][index] <= 1'b1;
                    dirty_q[w][index] <= 1'b0;   // fresh line is clean
                end else if (store_we && hit[w]) begin
                    dirty_q[w][index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < ASSOC_NUM; w++) begin
            if (refill_we && victim[w]) begin
                tag_mem[w][index] <= tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int ASSOC_NUM = 4
) (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire dcache_bus_pkg::cpu_req_t  cpu_req,
    input  wire dcache_bus_pkg::mem_resp_t mem_resp,
    input  wire logic [ASSOC_NUM-1:0]      hit,
    input  wire logic                      victim_dirty,
    output dcache_bus_pkg::cpu_req_t       held_req,
    output logic                           busy,
    output logic                           resp_valid,
    output logic                           rd_req,
    output logic                           wr_req,
    output logic                           refill_we,
    output logic                           store_we,
    output logic                           lru_update
);

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } state_e;

    state_e state;
    state_e state_next;

    dcache_bus_pkg::cpu_req_t req_q;   // payload only
    logic                     req_valid_q;
    logic                     lookup_hit;

    // the only cycle a request gets answered
    assign lookup_hit = (state == LOOKUP) && req_valid_q && (|hit);

    assign busy       = req_valid_q && !lookup_hit;
    assign resp_valid = lookup_hit;
    assign lru_update = lookup_hit;
    assign store_we   = lookup_hit && req_q.write;
    assign wr_req     = (state == MISS_DIRTY);
    assign rd_req     = (state == MISS_CLEAN);
    assign refill_we  = (state == REFILL) && mem_resp.ret_valid;

    always_comb begin
        held_req       = req_q;
        held_req.valid = req_valid_q;
    end

    // a new request is taken whenever the previous one is done
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid_q <= 1'b0;
        end else if (!busy) begin
            req_valid_q <= cpu_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && cpu_req.valid) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            LOOKUP: begin
                if (req_valid_q && !(|hit)) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (mem_resp.wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (mem_resp.wr_done) begin   // victim safe in memory
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_resp.rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_resp.ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: begin
                state_next = LOOKUP;   // lookup again, hits now
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: dcache_bus_pkg.sv
`default_nettype none

package dcache_bus_pkg;

    typedef enum logic [2:0] {
        LOAD_W  = 3'd0,
        LOAD_H  = 3'd1,
        LOAD_HU = 3'd2,
        LOAD_B  = 3'd3,
        LOAD_BU = 3'd4
    } load_type_e;

    typedef struct packed {
        logic                      valid;
        logic                      write;    // 1 = store
        dcache_geom_pkg::addr_t    addr;
        dcache_geom_pkg::byte_en_t wstrb;
        dcache_geom_pkg::word_t    wdata;
        load_type_e                load_type;
    } cpu_req_t;

    typedef struct packed {
        logic                   valid;
        dcache_geom_pkg::word_t rdata;
    } cpu_resp_t;

    // line-wide memory side, addresses are line aligned
    typedef struct packed {
        logic                   rd_req;
        logic                   wr_req;
        dcache_geom_pkg::addr_t rd_addr;
        dcache_geom_pkg::addr_t wr_addr;
        dcache_geom_pkg::line_t wr_data;
    } mem_req_t;

    typedef struct packed {
        logic                   rd_rdy;
        logic                   wr_rdy;
        logic                   ret_valid;
        logic                   wr_done;
        dcache_geom_pkg::line_t ret_data;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int SET_NUM    = 64;

    // byte offset inside a line, then set index, tag takes the rest
    localparam int OFFSET_W = $clog2(LINE_WORDS * WORD_W / 8);
    localparam int INDEX_W  = $clog2(SET_NUM);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;

    typedef logic [$clog2(LINE_WORDS)-1:0] word_sel_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

endpackage

`default_nettype wire
